//--- logic/fifo_cfg.svh
/* Dual-clock FIFO configuration
   Sizes of the storage array, the data word and the pointer synchronizers */

`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// Memory address bits, so the FIFO holds 2**FIFO_ADDR_WID words
// Needs at least 2 bits for the Gray full comparison
`define FIFO_ADDR_WID 2

// Width of one stored data word
`define FIFO_DATA_WID 8

// Flops per clock domain crossing
// Two is the usual choice, three buys more MTBF at the cost of flag latency
`define FIFO_SYNC_STAGES 2

`endif

//--- logic/fifoPkg.sv
/* Dual-clock FIFO types
   Data word, pointer and memory index types shared by all FIFO blocks */

`include "fifo_cfg.svh"

package fifoPkg;

    // ====================
    // Payload
    // ====================

    // One word as it is written, stored and read back
    typedef logic [`FIFO_DATA_WID-1:0] dataWord_t;

    // ====================
    // Pointers
    // ====================

    // Binary or Gray pointer with one extra top bit
    // The extra bit flips on every wrap, which tells a full FIFO apart from an empty one
    typedef logic [`FIFO_ADDR_WID:0] ptr_t;

    // Index into the storage array, the pointer without its wrap bit
    typedef logic [`FIFO_ADDR_WID-1:0] memAddr_t;

endpackage

//--- logic/memPortIf.sv
/* FIFO storage port bundle
   Write port from the write domain and read port from the read domain */

`timescale 1ns/1ps

interface memPortIf import fifoPkg::*; ();

    // Write port, valid on w_clk_i
    // A word is stored on every write clock edge where wrEn is high
    logic      wrEn;
    memAddr_t  wrAddr;
    dataWord_t wrData;

    // Read port, valid on r_clk_i
    // rdData is the registered word at rdAddr, one read cycle behind the address
    memAddr_t  rdAddr;
    dataWord_t rdData;

    // Write pointer logic owns the whole write port
    modport wrSide (
        output wrEn,
        output wrAddr,
        output wrData
    );

    // Read pointer logic supplies the address and takes the word back
    modport rdSide (
        output rdAddr,
        input  rdData
    );

    // The storage array sees both ports from the other direction
    modport memSide (
        input  wrEn,
        input  wrAddr,
        input  wrData,
        input  rdAddr,
        output rdData
    );

endinterface

//--- logic/cdcSync.sv
/* Pointer synchronizer
   Brings a Gray-coded pointer into the clock domain of r_clk_i through a flop chain */

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module cdcSync import fifoPkg::*; #(
    parameter int STAGES = `FIFO_SYNC_STAGES
) (
    // Destination clock, the side that reads the pointer
    input  logic r_clk_i,
    input  logic rstN_i,
    input  ptr_t ptr_i,
    output ptr_t ptr_o
);

    // Flop chain, index 0 is the first stage and may go metastable
    ptr_t syncQ [STAGES];

    // ====================
    // Sampling chain
    // ====================

    // The source pointer is Gray coded, so only one bit moves per source update
    // A late sample therefore resolves to either the old or the new pointer,
    // never to a mix of the two
    always_ff @(posedge r_clk_i) begin
        if (!rstN_i) begin
            // Zero matches the reset value of both pointers
            for (int i = 0; i < STAGES; i++) begin
                syncQ[i] <= '0;
            end
        end else begin
            syncQ[0] <= ptr_i;
            // Later stages only copy the settled value forward
            for (int i = 1; i < STAGES; i++) begin
                syncQ[i] <= syncQ[i-1];
            end
        end
    end

    // Only the last stage is safe to use in logic
    assign ptr_o = syncQ[STAGES-1];

endmodule

//--- logic/fifoMem.sv
/* FIFO storage array
   Written on w_clk_i, read through a registered port on r_clk_i */

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifoMem import fifoPkg::*; (
    input logic       w_clk_i,
    input logic       r_clk_i,
    memPortIf.memSide mem
);

    // Every slot is usable thanks to the wrap bit in the pointers
    localparam int DEPTH = 1 << `FIFO_ADDR_WID;

    // A slot is only read after it has been written, so stale contents never show
    dataWord_t memArray [DEPTH];

    // ====================
    // Write port
    // ====================

    // The word is stored at the same edge that the write pointer advances
    always_ff @(posedge w_clk_i) begin
        if (mem.wrEn) begin
            memArray[mem.wrAddr] <= mem.wrData;
        end
    end

    // ====================
    // Read port
    // ====================

    // Captured on every read edge, whether or not a pop happens
    // On the pop edge rdAddr still points at the popped slot,
    // so the popped word is held here until the following read edge
    always_ff @(posedge r_clk_i) begin
        mem.rdData <= memArray[mem.rdAddr];
    end

    // ====================
    // Checks
    // ====================

    // An unknown address would corrupt an unknown slot in the array
    aWrAddrKnown: assert property (
        @(posedge w_clk_i) mem.wrEn |-> !$isunknown(mem.wrAddr)
    ) else $error("FIFO write with unknown address");

endmodule

//--- logic/wrPtrCtrl.sv
/* FIFO write-side pointer logic
   Keeps the write pointer in binary and Gray code, flags full and drives the write port */

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module wrPtrCtrl import fifoPkg::*; (
    input  logic      w_clk_i,
    input  logic      rstN_i,
    input  logic      dataValid_i,
    input  dataWord_t data_i,
    output logic      full_o,
    // Read Gray pointer, already brought into this domain
    input  ptr_t      rdGraySync_i,
    output ptr_t      wrGray_o,
    memPortIf.wrSide  mem
);

    localparam int AW = `FIFO_ADDR_WID;

    // Binary pointer, its value after this cycle and the registered Gray copy
    ptr_t wrPtr;
    ptr_t wrPtrNext;
    ptr_t wrGray;
    logic wrHandshake;

    // ====================
    // Full flag
    // ====================

    // In binary, full means the wrap bits differ and the address bits match
    // In Gray code the top two bits both come out inverted and the rest match,
    // so no conversion back to binary is needed
    // The synchronized read pointer may lag, which only keeps full high too long
    assign full_o = (wrGray[AW:AW-1] == ~rdGraySync_i[AW:AW-1]) &&
                    (wrGray[AW-2:0] == rdGraySync_i[AW-2:0]);

    // Strobes while full are dropped, not queued
    assign wrHandshake = dataValid_i && !full_o;

    // ====================
    // Pointer update
    // ====================

    assign wrPtrNext = wrPtr + ptr_t'(wrHandshake);

    // The Gray copy is computed from the next pointer, so it changes at the
    // same edge as the binary pointer and full_o follows without extra delay
    always_ff @(posedge w_clk_i) begin
        if (!rstN_i) begin
            wrPtr  <= '0;
            wrGray <= '0;
        end else begin
            wrPtr  <= wrPtrNext;
            wrGray <= wrPtrNext ^ (wrPtrNext >> 1);
        end
    end

    // Only the registered Gray pointer leaves this domain
    assign wrGray_o = wrGray;

    // ====================
    // Write port
    // ====================

    // The low pointer bits select the slot, the wrap bit is not stored
    assign mem.wrEn   = wrHandshake;
    assign mem.wrAddr = wrPtr[AW-1:0];
    assign mem.wrData = data_i;

    // ====================
    // Checks
    // ====================

    aNoWriteWhenFull: assert property (
        @(posedge w_clk_i) disable iff (!rstN_i)
        full_o |=> (wrPtr == $past(wrPtr))
    ) else $error("Write pointer advanced while full");

    // The synchronizer in the read domain relies on this
    aWrGrayOneBit: assert property (
        @(posedge w_clk_i) disable iff (!rstN_i)
        $past(rstN_i) |-> ($countones(wrGray ^ $past(wrGray)) <= 1)
    ) else $error("Write Gray pointer changed more than one bit");

endmodule

//--- logic/rdPtrCtrl.sv
/* FIFO read-side pointer logic
   Keeps the read pointer in binary and Gray code, flags empty and addresses the read port */

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module rdPtrCtrl import fifoPkg::*; (
    input  logic     r_clk_i,
    input  logic     rstN_i,
    input  logic     popData_i,
    output logic     empty_o,
    // Write Gray pointer, already brought into this domain
    input  ptr_t     wrGraySync_i,
    output ptr_t     rdGray_o,
    memPortIf.rdSide mem
);

    localparam int AW = `FIFO_ADDR_WID;

    // Binary pointer, its value after this cycle and the registered Gray copy
    ptr_t rdPtr;
    ptr_t rdPtrNext;
    ptr_t rdGray;
    logic rdHandshake;

    // ====================
    // Empty flag
    // ====================

    // Each Gray code is unique, so plain equality still means both pointers
    // sit on the same slot with the same wrap count
    // The synchronized write pointer may lag, which only keeps empty high too long
    assign empty_o = (rdGray == wrGraySync_i);

    // Pops while empty are dropped, not queued
    assign rdHandshake = popData_i && !empty_o;

    // ====================
    // Pointer update
    // ====================

    assign rdPtrNext = rdPtr + ptr_t'(rdHandshake);

    // Gray copy follows the binary pointer at the same edge
    always_ff @(posedge r_clk_i) begin
        if (!rstN_i) begin
            rdPtr  <= '0;
            rdGray <= '0;
        end else begin
            rdPtr  <= rdPtrNext;
            rdGray <= rdPtrNext ^ (rdPtrNext >> 1);
        end
    end

    // The write side only ever sees the registered Gray pointer
    assign rdGray_o = rdGray;

    // ====================
    // Read port
    // ====================

    // The current pointer addresses the storage, not the next one
    // The storage registers this slot at the pop edge,
    // which gives the one-cycle read latency on the data output
    assign mem.rdAddr = rdPtr[AW-1:0];

    // ====================
    // Checks
    // ====================

    aNoPopWhenEmpty: assert property (
        @(posedge r_clk_i) disable iff (!rstN_i)
        empty_o |=> (rdPtr == $past(rdPtr))
    ) else $error("Read pointer advanced while empty");

    // The synchronizer in the write domain relies on this
    aRdGrayOneBit: assert property (
        @(posedge r_clk_i) disable iff (!rstN_i)
        $past(rstN_i) |-> ($countones(rdGray ^ $past(rdGray)) <= 1)
    ) else $error("Read Gray pointer changed more than one bit");

    // No known word can leave the storage before the first slot was ever written,
    // but once a pop is accepted the next read cycle must carry data
    aPopDataKnown: assert property (
        @(posedge r_clk_i) disable iff (!rstN_i)
        rdHandshake |=> !$isunknown(mem.rdData)
    ) else $error("Popped word is unknown");

endmodule

//--- logic/asyncFifo.sv
/* Dual-clock FIFO top level
   Connects the pointer logic, the pointer synchronizers and the storage array */

`timescale 1ns/1ps

module asyncFifo import fifoPkg::*; (
    // Write clock domain
    input  logic      w_clk_i,
    input  logic      dataValid_i,
    input  dataWord_t data_i,
    output logic      full_o,

    // Read clock domain
    input  logic      r_clk_i,
    input  logic      popData_i,
    output logic      empty_o,
    // Popped word, valid for one read cycle after the pop edge
    output dataWord_t data_o,

    // Sampled on both clocks, so it must be held across edges of each
    input  logic      rstN_i
);

    // Gray pointers in their own domain and after crossing
    ptr_t wrGray;
    ptr_t rdGray;
    ptr_t wrGraySync;
    ptr_t rdGraySync;

    // Storage access between the two pointer blocks and the array
    memPortIf memBus ();

    // ====================
    // Write domain
    // ====================

    wrPtrCtrl i_wrPtrCtrl (
        .w_clk_i      (w_clk_i),
        .rstN_i       (rstN_i),
        .dataValid_i  (dataValid_i),
        .data_i       (data_i),
        .full_o       (full_o),
        .rdGraySync_i (rdGraySync),
        .wrGray_o     (wrGray),
        .mem          (memBus.wrSide)
    );

    // Read pointer into the write domain, feeds the full flag
    cdcSync i_rdPtrSync (
        .r_clk_i (w_clk_i),
        .rstN_i  (rstN_i),
        .ptr_i   (rdGray),
        .ptr_o   (rdGraySync)
    );

    // ====================
    // Read domain
    // ====================

    rdPtrCtrl i_rdPtrCtrl (
        .r_clk_i      (r_clk_i),
        .rstN_i       (rstN_i),
        .popData_i    (popData_i),
        .empty_o      (empty_o),
        .wrGraySync_i (wrGraySync),
        .rdGray_o     (rdGray),
        .mem          (memBus.rdSide)
    );

    // Write pointer into the read domain, feeds the empty flag
    cdcSync i_wrPtrSync (
        .r_clk_i (r_clk_i),
        .rstN_i  (rstN_i),
        .ptr_i   (wrGray),
        .ptr_o   (wrGraySync)
    );

    // ====================
    // Storage
    // ====================

    fifoMem i_fifoMem (
        .w_clk_i (w_clk_i),
        .r_clk_i (r_clk_i),
        .mem     (memBus.memSide)
    );

    // Registered read port drives the output directly
    assign data_o = memBus.rdData;

endmodule

//--- verif/asyncFifoTb.sv
/* Dual-clock FIFO testbench
   Drives both clock domains and checks every popped word against a queue model */

`timescale 1ns/1ps

`include "fifo_cfg.svh"

module asyncFifoTb import fifoPkg::*; ();

    localparam int DEPTH = 1 << `FIFO_ADDR_WID;
    // Random phase length, counted once in write cycles and once in read cycles
    localparam int RANDOM_CYCLES = 500;
    // Longest wait for a write to reach the read side, with some slack over the synchronizer
    localparam int SYNC_WAIT = `FIFO_SYNC_STAGES + 3;
    localparam int DRAIN_LIMIT = 20;
    // The directed phases take about 40 read cycles and the random phase about 520,
    // so this limit is only hit when the run is stuck
    localparam int TIMEOUT_CYCLES = 4000;

    logic      w_clk_i;
    logic      r_clk_i;
    logic      rstN_i;
    logic      dataValid_i;
    dataWord_t data_i;
    logic      full_o;
    logic      popData_i;
    logic      empty_o;
    dataWord_t data_o;

    // Words written but not yet popped, oldest at the front
    dataWord_t modelQ [$];
    // Word expected on data_o at the next read edge
    dataWord_t pendingWord;
    logic      checkPending;
    int        dataErrors;
    int        flagErrors;
    int        cycleCount;
    int        seed;

    asyncFifo i_dut (
        .w_clk_i     (w_clk_i),
        .dataValid_i (dataValid_i),
        .data_i      (data_i),
        .full_o      (full_o),
        .r_clk_i     (r_clk_i),
        .popData_i   (popData_i),
        .empty_o     (empty_o),
        .data_o      (data_o),
        .rstN_i      (rstN_i)
    );

    // ====================
    // Clocks
    // ====================

    // 40 ns read clock and 28 ns write clock, so the edges keep sliding past each other
    initial begin
        r_clk_i = 1'b0;
        forever #20 r_clk_i = ~r_clk_i;
    end

    initial begin
        w_clk_i = 1'b0;
        forever #14 w_clk_i = ~w_clk_i;
    end

    // ====================
    // Reference model
    // ====================

    // A FIFO returns words in write order, so the expected word is the oldest one
    function automatic dataWord_t expectedWord();
        dataWord_t front;
        front = modelQ.pop_front();
        return front;
    endfunction

    task automatic reportDataError(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        dataErrors++;
    endtask

    task automatic logFlagError(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        flagErrors++;
    endtask

    // Write handshakes are taken from pre-edge values, just as the DUT sees them
    // The flags may lag the model but never run ahead of it, so a low full_o
    // always means there is room for one more word
    always @(posedge w_clk_i) begin
        if (rstN_i) begin
            if (full_o !== 1'b1 && modelQ.size() >= DEPTH) begin
                logFlagError($sformatf("full_o low with %0d words stored", modelQ.size()));
            end
            if (dataValid_i && !full_o) begin
                modelQ.push_back(data_i);
            end
        end
    end

    // The word popped at one read edge is on data_o until the next, so it is checked there
    always @(posedge r_clk_i) begin
        if (checkPending) begin
            if (data_o !== pendingWord) begin
                reportDataError($sformatf("data_o is %h, expected %h", data_o, pendingWord));
            end
        end
        checkPending = 1'b0;
        if (rstN_i) begin
            // A low empty_o must always be backed by at least one stored word
            if (empty_o !== 1'b1 && modelQ.size() == 0) begin
                logFlagError("empty_o low while the model holds no words");
            end
            if (popData_i && !empty_o) begin
                if (modelQ.size() == 0) begin
                    reportDataError("pop accepted with no word in the model");
                end else begin
                    pendingWord  = expectedWord();
                    checkPending = 1'b1;
                end
            end
        end
    end

    // ====================
    // Timeout
    // ====================

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge r_clk_i);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d read cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    // ====================
    // Test phases
    // ====================

    // Five read cycles of reset also span more than five write cycles
    task automatic applyReset();
        rstN_i <= 1'b0;
        repeat (5) @(posedge r_clk_i);
        #2;
        rstN_i <= 1'b1;
        @(posedge r_clk_i);
        #2;
        if (empty_o !== 1'b1) begin
            logFlagError("empty_o not high after reset");
        end
        if (full_o !== 1'b0) begin
            logFlagError("full_o not low after reset");
        end
    endtask

    // Waits on the read side until a written word becomes visible
    task automatic waitForData();
        int waited;
        waited = 0;
        while (empty_o && waited < SYNC_WAIT) begin
            @(posedge r_clk_i);
            #2;
            waited++;
        end
        if (empty_o !== 1'b0) begin
            logFlagError("empty_o still high long after a write");
        end
    endtask

    task automatic fillToFull();
        logic [31:0] rnd;
        for (int n = 0; n < DEPTH; n++) begin
            @(posedge w_clk_i);
            #2;
            if (full_o !== 1'b0) begin
                logFlagError($sformatf("full_o high before write %0d", n + 1));
            end
            rnd = $random(seed);
            dataValid_i <= 1'b1;
            data_i      <= dataWord_t'(rnd);
        end
        // The last write lands on this edge and full_o follows in the same cycle
        @(posedge w_clk_i);
        #2;
        if (full_o !== 1'b1) begin
            logFlagError($sformatf("full_o low right after write %0d", DEPTH));
        end
        // One more strobe with fresh data, which the full FIFO must drop
        rnd = $random(seed);
        data_i <= dataWord_t'(rnd);
        @(posedge w_clk_i);
        #2;
        dataValid_i <= 1'b0;
        if (modelQ.size() != DEPTH) begin
            reportDataError($sformatf("model holds %0d words after fill", modelQ.size()));
        end
    endtask

    task automatic drainInOrder();
        int popped;
        @(posedge r_clk_i);
        #2;
        waitForData();
        popped = 0;
        while (!empty_o && popped <= DEPTH) begin
            popData_i <= 1'b1;
            @(posedge r_clk_i);
            #2;
            popped++;
        end
        popData_i <= 1'b0;
        if (popped != DEPTH) begin
            reportDataError($sformatf("drained %0d words, expected %0d", popped, DEPTH));
        end
        // Nothing is written now, so empty_o has no reason to fall again
        repeat (4) begin
            @(posedge r_clk_i);
            #2;
            if (empty_o !== 1'b1) begin
                logFlagError("empty_o fell after the FIFO was drained");
            end
        end
    endtask

    task automatic popWhileEmpty();
        logic [31:0] rnd;
        // Ignored pop, the compare process flags it if the DUT accepts it
        popData_i <= 1'b1;
        @(posedge r_clk_i);
        #2;
        popData_i <= 1'b0;
        if (empty_o !== 1'b1) begin
            logFlagError("empty_o fell after a pop while empty");
        end
        rnd = $random(seed);
        @(posedge w_clk_i);
        #2;
        dataValid_i <= 1'b1;
        data_i      <= dataWord_t'(rnd);
        @(posedge w_clk_i);
        #2;
        dataValid_i <= 1'b0;
        @(posedge r_clk_i);
        #2;
        waitForData();
        popData_i <= 1'b1;
        @(posedge r_clk_i);
        #2;
        popData_i <= 1'b0;
        // The popped word is on data_o from the pop edge on
        if (data_o !== dataWord_t'(rnd)) begin
            reportDataError($sformatf("single pop gave %h, expected %h",
                                      data_o, dataWord_t'(rnd)));
        end
        @(posedge r_clk_i);
        #2;
        if (modelQ.size() != 0) begin
            reportDataError("model not empty after one write and one pop");
        end
    endtask

    // Both sides strobe at random with about half density
    task automatic randomTraffic();
        fork
            begin
                logic [31:0] rnd;
                repeat (RANDOM_CYCLES) begin
                    @(posedge w_clk_i);
                    #2;
                    rnd = $random(seed);
                    dataValid_i <= rnd[0];
                    data_i      <= dataWord_t'(rnd >> 8);
                end
                @(posedge w_clk_i);
                #2;
                dataValid_i <= 1'b0;
            end
            begin
                logic [31:0] rnd;
                repeat (RANDOM_CYCLES) begin
                    @(posedge r_clk_i);
                    #2;
                    rnd = $random(seed);
                    popData_i <= rnd[0];
                end
                @(posedge r_clk_i);
                #2;
                popData_i <= 1'b0;
            end
        join
    endtask

    // Pops whatever the random phase left behind
    task automatic flushRemaining();
        int waited;
        waited = 0;
        while ((modelQ.size() != 0 || !empty_o) && waited < DRAIN_LIMIT) begin
            popData_i <= 1'b1;
            @(posedge r_clk_i);
            #2;
            waited++;
        end
        popData_i <= 1'b0;
        @(posedge r_clk_i);
        #2;
        if (modelQ.size() != 0) begin
            reportDataError($sformatf("%0d words left in the model", modelQ.size()));
        end
        if (empty_o !== 1'b1) begin
            logFlagError("empty_o low after the final drain");
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        seed         = 32'ha410;
        rstN_i       = 1'b0;
        dataValid_i  = 1'b0;
        data_i       = '0;
        popData_i    = 1'b0;
        checkPending = 1'b0;
        dataErrors   = 0;
        flagErrors   = 0;
        applyReset();
        fillToFull();
        drainInOrder();
        popWhileEmpty();
        randomTraffic();
        flushRemaining();
        $display("Checks done: %0d data errors, %0d flag errors", dataErrors, flagErrors);
        if (dataErrors == 0 && flagErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+logic
logic/fifoPkg.sv
logic/memPortIf.sv
logic/cdcSync.sv
logic/fifoMem.sv
logic/wrPtrCtrl.sv
logic/rdPtrCtrl.sv
logic/asyncFifo.sv
verif/asyncFifoTb.sv

//--- Makefile
# Verilator build and run of the dual-clock FIFO testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := asyncFifoTb
FILELIST := src.f
PASS_MSG := Simulation passed

.PHONY: simulate clean

# Fails unless the run prints the pass message on a line of its own
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
